/* dv/fads_trace.txt */
# op addr_or_peak(hex) count(dec) data_or_expected(hex); T lines carry a test name
# W write, R read and compare, D droplet, Q quiet, S sort pulse (window, length), X reset
T defaults
R 0 0 F
R 8 0 FF
R 14 0 4
R 24 0 7A12
R 28 0 1E848
W 24 0 3
R 24 0 3
W 28 0 5
R 28 0 5
W 30 0 DEAD
R 30 0 0
T positive
Q 0 3 0
D 40 6 0
S 0 20 5
Q 0 3 0
R 110 0 1
R 200 0 1
R 204 0 40
R 208 0 6
R 20C 0 D2
T windows
Q 0 3 0
D F 6 0
Q 0 3 0
R 20C 0 51
D 100 6 0
Q 0 3 0
R 20C 0 54
D 40 2 0
Q 0 3 0
R 20C 0 4A
D 40 12 0
S 0 12 0
R 20C 0 62
R 100 0 1
R 104 0 1
R 108 0 1
R 10C 0 1
R 110 0 1
R 200 0 5
T min_width
W 10 0 3
Q 0 3 0
D 40 2 0
S 0 12 0
R 200 0 5
R 108 0 1
R 110 0 1
T reset
X 0 8 0
R 100 0 0
R 110 0 0
R 200 0 0
R 208 0 0
R 20C 0 0
R 10 0 1
R 28 0 1E848

/* project.f */
logic/fads_pkg.sv
logic/droplet_classifier.sv
logic/droplet_tracker.sv
logic/droplet_stats.sv
logic/fads_regs.sv
logic/red_pitaya_fads.sv
dv/fads_props.sv
dv/fads_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the FADS testbench with Verilator from the project root

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/100ps \
        -f project.f --top-module fads_tb --Mdir obj_dir -o fads_sim; then
    echo "build failed"
    exit 1
fi

if ! ./obj_dir/fads_sim > sim.log 2>&1; then
    cat sim.log
    echo "simulation exited with an error"
    exit 1
fi

cat sim.log
if grep -q "^NO ERRORS$" sim.log; then
    exit 0
fi
exit 1

/* dv/fads_tb.sv */
// replays dv/fads_trace.txt from the project root; each droplet must start while the tracker waits
module fads_tb import fads_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    // slack on top of the cycles the trace asks for
    localparam int TIMEOUT_MARGIN = 200;

    logic             adc_clk;
    logic             fads_reset;
    sample_t          adc_a;
    logic [BUS_W-1:0] sys_addr;
    logic [BUS_W-1:0] sys_wdata;
    logic             sys_wen;
    logic             sys_ren;
    logic [BUS_W-1:0] sys_rdata;
    logic             sys_ack;
    logic             sort_trig;

    int     fd;
    int     code;
    string  op;
    string  test_name;
    count_t a;
    int     n;
    count_t e;
    int     errors       = 0;
    int     test_errors  = 0;
    int     tests_passed = 0;
    int     tests_failed = 0;
    bit     in_test      = 1'b0;
    // set while a sort measurement owns the trigger
    bit     sort_watch   = 1'b0;
    bit     trig_seen    = 1'b0;
    // reset cycles plus whatever the trace lines add
    int     budget       = 8;
    int     cycles       = 0;

    red_pitaya_fads dut_i (
        .adc_clk_i  (adc_clk),
        .fads_reset (fads_reset),
        .adc_a_i    (adc_a),
        .sys_addr_i (sys_addr),
        .sys_wdata_i(sys_wdata),
        .sys_wen_i  (sys_wen),
        .sys_ren_i  (sys_ren),
        .sys_rdata_o(sys_rdata),
        .sys_ack_o  (sys_ack),
        .sort_trig_o(sort_trig)
    );

    initial begin
        adc_clk = 1'b0;
        forever #5 adc_clk = ~adc_clk;
    end

    // watchdog on total cycles
    always @(posedge adc_clk) begin
        cycles = cycles + 1;
        if (cycles > budget + TIMEOUT_MARGIN) begin
            $display("timeout after %0d cycles, the trace did not finish", cycles);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    // a pulse that starts outside a sort measurement is a spurious sort
    always @(negedge adc_clk) begin
        if (sort_trig === 1'b1 && !trig_seen && !sort_watch) begin
            $display("sort pulse fired outside a sort measurement");
            record_error();
        end
        trig_seen = (sort_trig === 1'b1);
    end

    task automatic record_error();
        errors      = errors + 1;
        test_errors = test_errors + 1;
    endtask

    task automatic check_rdata(input count_t addr, input count_t exp, input count_t act);
        if (act !== exp) begin
            $display("FAIL sys_rdata_o addr 0x%h expected 0x%h actual 0x%h", addr, exp, act);
            record_error();
        end
    endtask

    task automatic check_pulse(input count_t exp, input count_t act);
        if (act !== exp) begin
            $display("FAIL sort_trig_o length expected 0x%h actual 0x%h", exp, act);
            record_error();
        end
    endtask

    task automatic check_ack(input count_t addr);
        if (sys_ack !== 1'b1) begin
            $display("no ack from the DUT for the access to 0x%h", addr);
            record_error();
        end
    endtask

    // strobes last one cycle, ack and read data sampled after the next edge
    task automatic bus_write(input count_t addr, input count_t data);
        sys_addr  = addr;
        sys_wdata = data;
        sys_wen   = 1'b1;
        @(posedge adc_clk);
        #1;
        sys_wen = 1'b0;
        check_ack(addr);
    endtask

    task automatic bus_read(input count_t addr, input count_t exp);
        sys_addr = addr;
        sys_ren  = 1'b1;
        @(posedge adc_clk);
        #1;
        sys_ren = 1'b0;
        check_ack(addr);
        check_rdata(addr, exp, sys_rdata);
    endtask

    // flat droplet, every sample at the peak, then one low sample left driven
    task automatic drive_droplet(input sample_t peak, input int len);
        repeat (len) begin
            adc_a = peak;
            @(posedge adc_clk);
            #1;
        end
        adc_a = '0;
    endtask

    task automatic drive_quiet(input int len);
        adc_a = '0;
        repeat (len) begin
            @(posedge adc_clk);
            #1;
        end
    endtask

    task automatic apply_reset(input int len);
        fads_reset = 1'b1;
        repeat (len) begin
            @(posedge adc_clk);
            #1;
        end
        fads_reset = 1'b0;
    endtask

    // waits up to window cycles for a pulse, exp of zero means none allowed
    task automatic measure_sort(input int window, input count_t exp);
        int     waited;
        count_t len;
        waited     = 0;
        len        = '0;
        sort_watch = 1'b1;
        while (!sort_trig && waited < window) begin
            @(posedge adc_clk);
            #1;
            waited = waited + 1;
        end
        if (!sort_trig) begin
            if (exp != 0) begin
                $display("no sort pulse seen within %0d cycles", window);
                record_error();
            end
        end else if (exp == 0) begin
            $display("sort pulse fired for a droplet that should not sort");
            record_error();
        end else begin
            while (sort_trig && len <= exp) begin
                len = len + 32'd1;
                @(posedge adc_clk);
                #1;
            end
            check_pulse(exp, len);
        end
        // a pulse already reported here is not reported again
        trig_seen  = (sort_trig === 1'b1);
        sort_watch = 1'b0;
    endtask

    task automatic close_test();
        if (in_test) begin
            if (test_errors == 0) begin
                tests_passed = tests_passed + 1;
                $display("test %s passed", test_name);
            end else begin
                tests_failed = tests_failed + 1;
                $display("test %s failed with %0d errors", test_name, test_errors);
            end
        end
        test_errors = 0;
    endtask

    task automatic skip_comment(input int fdesc);
        int c;
        c = $fgetc(fdesc);
        while (c != 10 && c != -1) begin
            c = $fgetc(fdesc);
        end
    endtask

    initial begin
        adc_a      = '0;
        sys_addr   = '0;
        sys_wdata  = '0;
        sys_wen    = 1'b0;
        sys_ren    = 1'b0;
        fads_reset = 1'b1;
        repeat (8) @(posedge adc_clk);
        #1;
        fads_reset = 1'b0;
        fd = $fopen("dv/fads_trace.txt", "r");
        if (fd == 0) begin
            $display("cannot open the trace file dv/fads_trace.txt");
            errors = errors + 1;
        end else begin
            while (!$feof(fd)) begin
                code = $fscanf(fd, "%s", op);
                if (code != 1) begin
                    break;
                end
                if (op == "#") begin
                    skip_comment(fd);
                end else if (op == "T") begin
                    close_test();
                    code    = $fscanf(fd, "%s", test_name);
                    in_test = 1'b1;
                end else begin
                    code   = $fscanf(fd, "%h %d %h", a, n, e);
                    budget = budget + n + 4;
                    if (op == "W") begin
                        bus_write(a, e);
                    end else if (op == "R") begin
                        bus_read(a, e);
                    end else if (op == "D") begin
                        drive_droplet(a[SAMPLE_W-1:0], n);
                    end else if (op == "Q") begin
                        drive_quiet(n);
                    end else if (op == "S") begin
                        budget = budget + int'(e);
                        measure_sort(n, e);
                    end else if (op == "X") begin
                        apply_reset(n);
                    end else begin
                        $display("unknown opcode %s in the trace", op);
                        record_error();
                    end
                end
            end
            close_test();
            $fclose(fd);
        end
        $display("tests passed %0d, tests failed %0d, errors %0d",
                 tests_passed, tests_failed, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

/* dv/fads_props.sv */
// bus ack and sort trigger checks; sort_duration must not be rewritten while a pulse is running
module fads_props import fads_pkg::*; (
    input logic   adc_clk_i,
    input logic   fads_reset,
    input logic   wen_i,
    input logic   ren_i,
    input logic   ack_i,
    input logic   trig_i,
    input count_t duration_i
);
    timeunit 1ns;
    timeprecision 100ps;

    count_t run_len;

    // high cycles of the current sort pulse before this one
    always_ff @(posedge adc_clk_i) begin
        if (fads_reset || !trig_i) begin
            run_len <= '0;
        end else begin
            run_len <= run_len + 32'd1;
        end
    end

    ack_after_strobe: assert property (@(posedge adc_clk_i) disable iff (fads_reset)
        (wen_i || ren_i) |=> ack_i)
        else $error("sys_ack_o missing after a bus strobe");

    // no spurious acks
    ack_only_after_strobe: assert property (@(posedge adc_clk_i) disable iff (fads_reset)
        ack_i |-> $past(wen_i || ren_i))
        else $error("sys_ack_o high without a strobe on the previous cycle");

    trig_low_after_reset: assert property (@(posedge adc_clk_i)
        fads_reset |=> !trig_i)
        else $error("sort_trig_o high in the cycle after reset");

    trig_within_duration: assert property (@(posedge adc_clk_i) disable iff (fads_reset)
        trig_i |-> (run_len < duration_i))
        else $error("sort_trig_o pulse longer than sort_duration");

endmodule

bind red_pitaya_fads fads_props props_i (
    .adc_clk_i (adc_clk_i),
    .fads_reset(fads_reset),
    .wen_i     (sys_wen_i),
    .ren_i     (sys_ren_i),
    .ack_i     (sys_ack_o),
    .trig_i    (sort_trig_o),
    .duration_i(cfg.sort_duration)
);

/* logic/red_pitaya_fads.sv */
// FADS top; single ADC channel, all logic on adc_clk_i, fads_reset synchronous active high
module red_pitaya_fads import fads_pkg::*; (
    input  logic             adc_clk_i,
    input  logic             fads_reset,
    input  sample_t          adc_a_i,
    input  logic [BUS_W-1:0] sys_addr_i,
    input  logic [BUS_W-1:0] sys_wdata_i,
    input  logic             sys_wen_i,
    input  logic             sys_ren_i,
    output logic [BUS_W-1:0] sys_rdata_o,
    output logic             sys_ack_o,
    output logic             sort_trig_o
);

    sys_bus_req_t   bus_req;
    fads_cfg_t      cfg;
    droplet_meas_t  meas;
    droplet_class_t dclass;
    fads_stats_t    stats;
    logic           eval;

    // bus pins into one request
    assign bus_req.addr  = sys_addr_i;
    assign bus_req.wdata = sys_wdata_i;
    assign bus_req.wen   = sys_wen_i;
    assign bus_req.ren   = sys_ren_i;

    fads_regs regs_i (
        .adc_clk_i (adc_clk_i),
        .fads_reset(fads_reset),
        .bus_i     (bus_req),
        .stats_i   (stats),
        .cfg_o     (cfg),
        .rdata_o   (sys_rdata_o),
        .ack_o     (sys_ack_o)
    );

    droplet_tracker tracker_i (
        .adc_clk_i  (adc_clk_i),
        .fads_reset (fads_reset),
        .sample_i   (adc_a_i),
        .cfg_i      (cfg),
        .dclass_i   (dclass),
        .meas_o     (meas),
        .eval_o     (eval),
        .sort_trig_o(sort_trig_o)
    );

    droplet_classifier class_i (
        .meas_i  (meas),
        .cfg_i   (cfg),
        .dclass_o(dclass)
    );

    droplet_stats stats_i (
        .adc_clk_i (adc_clk_i),
        .fads_reset(fads_reset),
        .eval_i    (eval),
        .meas_i    (meas),
        .dclass_i  (dclass),
        .stats_o   (stats)
    );

endmodule

/* logic/fads_regs.sv */
// bus register file; every strobe is acked next cycle, unmapped addresses read zero, 14-bit fields zero-extended
module fads_regs import fads_pkg::*; (
    input  logic             adc_clk_i,
    input  logic             fads_reset,
    input  sys_bus_req_t     bus_i,
    input  fads_stats_t      stats_i,
    output fads_cfg_t        cfg_o,
    output logic [BUS_W-1:0] rdata_o,
    output logic             ack_o
);

    fads_cfg_t        cfg_q;
    fads_reg_e        addr;
    logic             bus_en;
    logic [BUS_W-1:0] rd_word;

    // only the low address bits are decoded
    assign addr   = fads_reg_e'(bus_i.addr[ADDR_DEC_W-1:0]);
    assign bus_en = bus_i.wen | bus_i.ren;
    assign cfg_o  = cfg_q;

    // configuration registers
    always_ff @(posedge adc_clk_i) begin
        if (fads_reset) begin
            cfg_q.min_int       <= MIN_INT_DEFAULT;
            cfg_q.low_int       <= LOW_INT_DEFAULT;
            cfg_q.high_int      <= HIGH_INT_DEFAULT;
            cfg_q.min_width     <= MIN_WIDTH_DEFAULT;
            cfg_q.low_width     <= LOW_WIDTH_DEFAULT;
            cfg_q.high_width    <= HIGH_WIDTH_DEFAULT;
            cfg_q.sort_delay    <= SORT_DELAY_DEFAULT;
            cfg_q.sort_duration <= SORT_DURATION_DEFAULT;
        end else if (bus_i.wen) begin
            case (addr)
                // thresholds take the low 14 bits
                REG_MIN_INT:       cfg_q.min_int       <= bus_i.wdata[SAMPLE_W-1:0];
                REG_LOW_INT:       cfg_q.low_int       <= bus_i.wdata[SAMPLE_W-1:0];
                REG_HIGH_INT:      cfg_q.high_int      <= bus_i.wdata[SAMPLE_W-1:0];
                REG_MIN_WIDTH:     cfg_q.min_width     <= bus_i.wdata;
                REG_LOW_WIDTH:     cfg_q.low_width     <= bus_i.wdata;
                REG_HIGH_WIDTH:    cfg_q.high_width    <= bus_i.wdata;
                REG_SORT_DELAY:    cfg_q.sort_delay    <= bus_i.wdata;
                REG_SORT_DURATION: cfg_q.sort_duration <= bus_i.wdata;
                // counters and record are read only
                default: ;
            endcase
        end
    end

    // read word mux
    always_comb begin
        case (addr)
            REG_MIN_INT:        rd_word = {{(BUS_W-SAMPLE_W){1'b0}}, cfg_q.min_int};
            REG_LOW_INT:        rd_word = {{(BUS_W-SAMPLE_W){1'b0}}, cfg_q.low_int};
            REG_HIGH_INT:       rd_word = {{(BUS_W-SAMPLE_W){1'b0}}, cfg_q.high_int};
            REG_MIN_WIDTH:      rd_word = cfg_q.min_width;
            REG_LOW_WIDTH:      rd_word = cfg_q.low_width;
            REG_HIGH_WIDTH:     rd_word = cfg_q.high_width;
            REG_SORT_DELAY:     rd_word = cfg_q.sort_delay;
            REG_SORT_DURATION:  rd_word = cfg_q.sort_duration;
            REG_LOW_INT_CNT:    rd_word = stats_i.low_int_cnt;
            REG_HIGH_INT_CNT:   rd_word = stats_i.high_int_cnt;
            REG_SHORT_CNT:      rd_word = stats_i.short_cnt;
            REG_LONG_CNT:       rd_word = stats_i.long_cnt;
            REG_POSITIVE_CNT:   rd_word = stats_i.positive_cnt;
            REG_DROPLET_ID:     rd_word = stats_i.droplet_id;
            REG_LAST_INTENSITY: rd_word = {{(BUS_W-SAMPLE_W){1'b0}}, stats_i.last_meas.peak};
            REG_LAST_WIDTH:     rd_word = stats_i.last_meas.width;
            REG_LAST_CLASS: begin
                rd_word = {{(BUS_W-$bits(droplet_class_t)){1'b0}}, stats_i.last_class};
            end
            default:            rd_word = '0;
        endcase
    end

    // ack one cycle after any strobe
    always_ff @(posedge adc_clk_i) begin
        if (fads_reset) begin
            ack_o <= 1'b0;
        end else begin
            ack_o <= bus_en;
        end
    end

    // read data captured with the strobe, valid alongside ack
    always_ff @(posedge adc_clk_i) begin
        if (bus_en) begin
            rdata_o <= rd_word;
        end
    end

endmodule

/* logic/droplet_stats.sv */
// class counters and latest-droplet record; only droplets with width >= min_width are recorded
module droplet_stats import fads_pkg::*; (
    input  logic           adc_clk_i,
    input  logic           fads_reset,
    input  logic           eval_i,
    input  droplet_meas_t  meas_i,
    input  droplet_class_t dclass_i,
    output fads_stats_t    stats_o
);

    fads_stats_t stats_q;

    assign stats_o = stats_q;

    always_ff @(posedge adc_clk_i) begin
        if (fads_reset) begin
            stats_q <= '0;
        end else if (eval_i && dclass_i.counted) begin
            // each counter follows its own class bit
            if (dclass_i.low_int) begin
                stats_q.low_int_cnt <= stats_q.low_int_cnt + 32'd1;
            end
            if (dclass_i.high_int) begin
                stats_q.high_int_cnt <= stats_q.high_int_cnt + 32'd1;
            end
            if (dclass_i.short_width) begin
                stats_q.short_cnt <= stats_q.short_cnt + 32'd1;
            end
            if (dclass_i.long_width) begin
                stats_q.long_cnt <= stats_q.long_cnt + 32'd1;
            end
            if (dclass_i.positive) begin
                stats_q.positive_cnt <= stats_q.positive_cnt + 32'd1;
            end
            // id of the droplet now in the record
            stats_q.droplet_id <= stats_q.droplet_id + 32'd1;
            stats_q.last_meas  <= meas_i;
            stats_q.last_class <= dclass_i;
        end
    end

endmodule

/* logic/droplet_tracker.sv */
// acquire/sort FSM; samples ignored outside wait and acquire, width counts only samples at or above min_int
module droplet_tracker import fads_pkg::*; (
    input  logic           adc_clk_i,
    input  logic           fads_reset,
    input  sample_t        sample_i,
    input  fads_cfg_t      cfg_i,
    input  droplet_class_t dclass_i,
    output droplet_meas_t  meas_o,
    output logic           eval_o,
    output logic           sort_trig_o
);

    fads_state_e state_q;
    sample_t     min_int;
    sample_t     peak_q;
    count_t      width_q;
    count_t      delay_cnt_q;
    count_t      dur_cnt_q;
    logic        above;
    logic        sort_last;

    // signed threshold compare on the live sample
    assign min_int = cfg_i.min_int;
    assign above   = sample_i >= min_int;

    // no wrap, dur_cnt_q stays below sort_duration
    assign sort_last = (dur_cnt_q + 32'd1) >= cfg_i.sort_duration;

    assign meas_o.peak  = peak_q;
    assign meas_o.width = width_q;

    // classifier result is sampled here
    assign eval_o = (state_q == ST_EVALUATE);

    // high for sort_duration cycles, never for a zero duration
    assign sort_trig_o = (state_q == ST_SORT) && (dur_cnt_q < cfg_i.sort_duration);

    // state and timers
    always_ff @(posedge adc_clk_i) begin
        if (fads_reset) begin
            state_q     <= ST_IDLE;
            delay_cnt_q <= '0;
            dur_cnt_q   <= '0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    state_q <= ST_WAIT;
                end
                ST_WAIT: begin
                    if (above) begin
                        state_q <= ST_ACQUIRE;
                    end
                end
                ST_ACQUIRE: begin
                    // first low sample ends the droplet
                    if (!above) begin
                        state_q <= ST_EVALUATE;
                    end
                end
                ST_EVALUATE: begin
                    if (dclass_i.positive) begin
                        delay_cnt_q <= '0;
                        state_q     <= ST_SORT_DELAY;
                    end else begin
                        state_q <= ST_IDLE;
                    end
                end
                ST_SORT_DELAY: begin
                    // sort_delay + 1 cycles here
                    if (delay_cnt_q >= cfg_i.sort_delay) begin
                        dur_cnt_q <= '0;
                        state_q   <= ST_SORT;
                    end else begin
                        delay_cnt_q <= delay_cnt_q + 32'd1;
                    end
                end
                ST_SORT: begin
                    if (sort_last) begin
                        state_q <= ST_IDLE;
                    end else begin
                        dur_cnt_q <= dur_cnt_q + 32'd1;
                    end
                end
                default: begin
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

    // peak hold and width counter, loaded on droplet start
    always_ff @(posedge adc_clk_i) begin
        if (state_q == ST_WAIT && above) begin
            peak_q  <= sample_i;
            width_q <= 32'd1;
        end else if (state_q == ST_ACQUIRE && above) begin
            width_q <= width_q + 32'd1;
            if (sample_i > peak_q) begin
                peak_q <= sample_i;
            end
        end
    end

endmodule

/* logic/droplet_classifier.sv */
// pure combinational windows; assumes min <= low <= high for both intensity and width thresholds
module droplet_classifier import fads_pkg::*; (
    input  droplet_meas_t  meas_i,
    input  fads_cfg_t      cfg_i,
    output droplet_class_t dclass_o
);

    // local copies keep the compares signed
    sample_t peak;
    sample_t min_int;
    sample_t low_int;
    sample_t high_int;
    count_t  width;
    logic    counted;
    logic    pos_int;
    logic    pos_width;

    assign peak     = meas_i.peak;
    assign min_int  = cfg_i.min_int;
    assign low_int  = cfg_i.low_int;
    assign high_int = cfg_i.high_int;
    assign width    = meas_i.width;

    // intensity windows, signed
    assign dclass_o.low_int  = (peak >= min_int) && (peak < low_int);
    assign pos_int           = (peak >= low_int) && (peak < high_int);
    assign dclass_o.pos_int  = pos_int;
    assign dclass_o.high_int = peak >= high_int;

    // droplet long enough to count at all
    assign counted          = width >= cfg_i.min_width;
    assign dclass_o.counted = counted;

    // width windows, unsigned, gated by counted
    assign dclass_o.short_width = counted && (width < cfg_i.low_width);
    assign pos_width = counted && (width >= cfg_i.low_width) && (width < cfg_i.high_width);
    assign dclass_o.pos_width   = pos_width;
    assign dclass_o.long_width  = counted && (width >= cfg_i.high_width);

    // sort candidate
    assign dclass_o.positive = pos_int && pos_width;

endmodule

/* logic/fads_pkg.sv */
// shared FADS types; one signed 14-bit ADC channel, register map decoded on address bits [19:0] only
package fads_pkg;

    // datapath sizes
    localparam int SAMPLE_W   = 14;
    localparam int CNT_W      = 32;
    localparam int BUS_W      = 32;
    localparam int ADDR_DEC_W = 20;

    // signed adc sample, two's complement
    typedef logic signed [SAMPLE_W-1:0] sample_t;
    typedef logic [CNT_W-1:0]           count_t;

    // threshold defaults after reset
    localparam sample_t MIN_INT_DEFAULT       = 14'sd15;
    localparam sample_t LOW_INT_DEFAULT       = 14'sd16;
    localparam sample_t HIGH_INT_DEFAULT      = 14'sd255;
    localparam count_t  MIN_WIDTH_DEFAULT     = 32'd1;
    localparam count_t  LOW_WIDTH_DEFAULT     = 32'd4;
    localparam count_t  HIGH_WIDTH_DEFAULT    = 32'd10;
    // 250 us and 1 ms at 125 MHz
    localparam count_t  SORT_DELAY_DEFAULT    = 32'd31250;
    localparam count_t  SORT_DURATION_DEFAULT = 32'd125000;

    // tracker states
    typedef enum logic [2:0] {
        ST_IDLE       = 3'd0,
        ST_WAIT       = 3'd1,
        ST_ACQUIRE    = 3'd2,
        ST_EVALUATE   = 3'd3,
        ST_SORT_DELAY = 3'd4,
        ST_SORT       = 3'd5
    } fads_state_e;

    // register map, byte addresses
    typedef enum logic [ADDR_DEC_W-1:0] {
        REG_MIN_INT        = 20'h00000,
        REG_LOW_INT        = 20'h00004,
        REG_HIGH_INT       = 20'h00008,
        REG_MIN_WIDTH      = 20'h00010,
        REG_LOW_WIDTH      = 20'h00014,
        REG_HIGH_WIDTH     = 20'h00018,
        REG_SORT_DELAY     = 20'h00024,
        REG_SORT_DURATION  = 20'h00028,
        // class counters, read only
        REG_LOW_INT_CNT    = 20'h00100,
        REG_HIGH_INT_CNT   = 20'h00104,
        REG_SHORT_CNT      = 20'h00108,
        REG_LONG_CNT       = 20'h0010C,
        REG_POSITIVE_CNT   = 20'h00110,
        // latest droplet record, read only
        REG_DROPLET_ID     = 20'h00200,
        REG_LAST_INTENSITY = 20'h00204,
        REG_LAST_WIDTH     = 20'h00208,
        REG_LAST_CLASS     = 20'h0020C
    } fads_reg_e;

    typedef struct packed {
        sample_t min_int;
        sample_t low_int;
        sample_t high_int;
        count_t  min_width;
        count_t  low_width;
        count_t  high_width;
        count_t  sort_delay;
        count_t  sort_duration;
    } fads_cfg_t;

    // field order gives the register bit order, msb first
    typedef struct packed {
        logic positive;
        logic counted;
        logic long_width;
        logic pos_width;
        logic short_width;
        logic high_int;
        logic pos_int;
        logic low_int;
    } droplet_class_t;

    typedef struct packed {
        sample_t peak;
        count_t  width;
    } droplet_meas_t;

    typedef struct packed {
        count_t         low_int_cnt;
        count_t         high_int_cnt;
        count_t         short_cnt;
        count_t         long_cnt;
        count_t         positive_cnt;
        count_t         droplet_id;
        droplet_meas_t  last_meas;
        droplet_class_t last_class;
    } fads_stats_t;

    // plain strobe bus, no back-pressure
    typedef struct packed {
        logic [BUS_W-1:0] addr;
        logic [BUS_W-1:0] wdata;
        logic             wen;
        logic             ren;
    } sys_bus_req_t;

endpackage
